// File: sim/video_input.txt
# W <cpu addr hex> <data hex> is one CPU write strobe, addr bit 9 selects the palette
# P <scr1> <scr2> <scr3> <obj> <expected rgb hex>, each layer pixel is {pal, colour} in hex
W 200 0123
W 212 0A00
W 2A3 00B0
W 334 000C
W 3C5 0DEF
P 12 23 34 45 DDEEFF
P 12 23 34 4F 0000CC
P 12 23 3F 4F 00BB00
P 1F 2F 3F 4F 112233
W 001 0007
P 12 23 34 45 0000CC
W 001 0003
P 12 2F 34 45 AA0000
W 001 0000
P 12 23 34 45 112233
W 001 000F
W 000 00B1
P 12 23 34 45 00BB00
P 12 2F 34 45 AA0000
P 1F 2F 34 45 DDEEFF

// File: project.f
+incdir+source
source/video_pkg.sv
source/video_timing.sv
source/video_regs.sv
source/layer_mixer.sv
source/palette_lut.sv
source/video_core.sv
sim/tb_video_core.sv

// File: Bender.yml
package:
  name: video_core

sources:
  - include_dirs:
      - source
    files:
      - source/video_pkg.sv
      - source/video_timing.sv
      - source/video_regs.sv
      - source/layer_mixer.sv
      - source/palette_lut.sv
      - source/video_core.sv
  - target: test
    include_dirs:
      - source
    files:
      - sim/tb_video_core.sv

// File: sim/tb_video_core.sv
// Self-checking testbench for video_core driven by the stimulus and colours of the input file
`timescale 1ns/1ps
`default_nettype none
`include "video_defs.svh"

module tb_video_core;

    // Raster figures as the display spec states them
    localparam int LINE_ENABLES   = 512;
    localparam int ACTIVE_ENABLES = 384;
    localparam int FRAME_LINES    = 262;
    localparam int ACTIVE_LINES   = 224;
    localparam int FRAME_LIMIT    = 140000;

    logic                  clk;
    logic                  rst;
    logic                  pxl_cen;
    video_pkg::cpu_wr_t    cpu;
    video_pkg::layers_t    layers;
    wire [8:0]             hdump;
    wire [8:0]             vdump;
    wire video_pkg::sync_t sync;
    wire video_pkg::rgb_t  rgb;
    wire                   lhbl_dly;
    wire                   lvbl_dly;

    int                    value_errors;
    int                    timeout_errors;
    int                    setup_errors;
    int                    enable_cnt;
    // Raster position expected after each enable
    int                    exp_h;
    int                    exp_v;
    // Blanking after each enable with bit 3 three enables back
    logic [3:0]            hb_hist;
    logic [3:0]            vb_hist;
    int                    due_q[$];
    logic [23:0]           exp_q[$];

    video_core dut_i (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .cpu      (cpu),
        .layers   (layers),
        .hdump    (hdump),
        .vdump    (vdump),
        .sync     (sync),
        .rgb      (rgb),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic finish_run();
        $display("Errors: %0d value, %0d timeout, %0d setup",
                 value_errors, timeout_errors, setup_errors);
        if (value_errors + timeout_errors + setup_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        timeout_errors++;
        $display("Timed out at %0t ns while waiting for %s", $time, what);
        finish_run();
    endtask

    task automatic check_true(input logic ok, input string what);
        assert (ok) else begin
            value_errors++;
            $display("FAIL %0t ns: %s", $time, what);
        end
    endtask

    task automatic check_reset_state();
        check_true(rgb == '0, "rgb not zero after reset");
        check_true(!lhbl_dly && !lvbl_dly, "delayed blanking not low after reset");
        check_true(!sync.hs && !sync.vs, "sync pulse active after reset");
        check_true(sync.hb && sync.vb, "blanking not active after reset");
        check_true(hdump == 0 && vdump == 0, "raster counters not zero after reset");
    endtask

    // One enable cycle followed by one idle cycle
    task automatic step_enable();
        logic [23:0] expected;
        pxl_cen = 1'b1;
        @(posedge clk);
        #2;
        pxl_cen = 1'b0;
        enable_cnt++;
        exp_h = (exp_h + 1) % `H_TOTAL;
        if (exp_h == 0) begin
            exp_v = (exp_v + 1) % `V_TOTAL;
        end
        check_true(hdump == exp_h && vdump == exp_v,
                   $sformatf("position %0d/%0d, expected %0d/%0d",
                             hdump, vdump, exp_h, exp_v));
        hb_hist = {hb_hist[2:0], sync.hb};
        vb_hist = {vb_hist[2:0], sync.vb};
        check_true(lhbl_dly == !hb_hist[3], "lhbl_dly not three enables behind hb");
        check_true(lvbl_dly == !vb_hist[3], "lvbl_dly not three enables behind vb");
        if (hb_hist[3] || vb_hist[3]) begin
            check_true(rgb == '0, $sformatf("rgb %h during blanking", rgb));
        end
        if (due_q.size() > 0 && due_q[0] == enable_cnt) begin
            void'(due_q.pop_front());
            expected = exp_q.pop_front();
            check_true(rgb == expected, $sformatf("rgb %h, expected %h", rgb, expected));
        end
        @(posedge clk);
        #2;
    endtask

    task automatic wait_visible();
        int guard;
        guard = 0;
        while (sync.hb || sync.vb) begin
            step_enable();
            guard++;
            if (guard > FRAME_LIMIT) begin
                abort_on_timeout("the visible area");
            end
        end
    endtask

    task automatic flush_pipeline();
        int guard;
        guard = 0;
        while (due_q.size() > 0) begin
            step_enable();
            guard++;
            if (guard > `PAL_LATENCY + 1) begin
                abort_on_timeout("pending pixels to reach rgb");
            end
        end
    endtask

    // Pixels in flight must not see the new setting
    task automatic apply_write(input logic [9:0] addr, input logic [15:0] data);
        flush_pipeline();
        cpu = '{we: 1'b1, addr: addr, data: data};
        @(posedge clk);
        #2;
        cpu.we = 1'b0;
        @(posedge clk);
        #2;
    endtask

    task automatic apply_pixel(input video_pkg::layers_t px, input logic [23:0] expected);
        wait_visible();
        layers = px;
        due_q.push_back(enable_cnt + `PAL_LATENCY);
        exp_q.push_back(expected);
        step_enable();
        layers = '1;
    endtask

    // Runs from one rising vs to the next and checks the raster sizes
    task automatic measure_frame();
        int   guard;
        int   line_len;
        int   hb_low;
        int   lines;
        int   active_lines;
        logic prev_hs;
        logic prev_vs;
        logic seen_hs;
        guard = 0;
        do begin
            prev_vs = sync.vs;
            step_enable();
            guard++;
            if (guard > FRAME_LIMIT) begin
                abort_on_timeout("the first rising vs");
            end
        end while (!(sync.vs && !prev_vs));
        guard = 0;
        line_len = 0;
        hb_low = 0;
        lines = 0;
        active_lines = 0;
        seen_hs = 1'b0;
        do begin
            prev_hs = sync.hs;
            prev_vs = sync.vs;
            step_enable();
            guard++;
            line_len++;
            if (!sync.hb) begin
                hb_low++;
            end
            if (sync.hs && !prev_hs) begin
                if (seen_hs) begin
                    check_true(line_len == LINE_ENABLES,
                               $sformatf("line of %0d enables", line_len));
                    check_true(hb_low == ACTIVE_ENABLES,
                               $sformatf("%0d enables with hb low in a line", hb_low));
                end
                seen_hs = 1'b1;
                lines++;
                if (!sync.vb) begin
                    active_lines++;
                end
                line_len = 0;
                hb_low = 0;
            end
            if (guard > FRAME_LIMIT) begin
                abort_on_timeout("the rising vs that ends the frame");
            end
        end while (!(sync.vs && !prev_vs));
        check_true(lines == FRAME_LINES, $sformatf("frame of %0d lines", lines));
        check_true(active_lines == ACTIVE_LINES,
                   $sformatf("%0d lines with vb low", active_lines));
    endtask

    initial begin
        int          fd;
        string       line;
        logic [31:0] f0;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        value_errors = 0;
        timeout_errors = 0;
        setup_errors = 0;
        enable_cnt = 0;
        exp_h = 0;
        exp_v = 0;
        hb_hist = 4'hf;
        vb_hist = 4'hf;
        rst = 1'b1;
        pxl_cen = 1'b0;
        cpu = '0;
        layers = '1;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        check_reset_state();
        fd = $fopen("sim/video_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file sim/video_input.txt");
            setup_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.getc(0) == "W" && $sscanf(line, "W %h %h", f0, f1) == 2) begin
                    apply_write(f0[9:0], f1[15:0]);
                end else if (line.getc(0) == "P" &&
                             $sscanf(line, "P %h %h %h %h %h", f0, f1, f2, f3, f4) == 5) begin
                    apply_pixel({f0[6:0], f1[6:0], f2[6:0], f3[6:0]}, f4[23:0]);
                end else if (line.getc(0) != "#" && line.len() > 1) begin
                    $display("Unreadable stimulus line: %s", line);
                    setup_errors++;
                end
            end
            $fclose(fd);
            flush_pipeline();
            measure_frame();
        end
        finish_run();
    end

endmodule

`default_nettype wire

// File: source/video_core.sv
// Top level of the video pixel back end joining timing, registers, mixer and palette
`timescale 1ns/1ps
`default_nettype none

module video_core (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          pxl_cen,
    input  wire video_pkg::cpu_wr_t      cpu,
    input  wire video_pkg::layers_t      layers,
    output wire [8:0]                    hdump,
    output wire [8:0]                    vdump,
    output wire video_pkg::sync_t        sync,
    output wire video_pkg::rgb_t         rgb,
    output wire                          lhbl_dly,
    output wire                          lvbl_dly
);

    video_pkg::mix_cfg_t   cfg;
    video_pkg::pal_wr_t    pal_wr;
    video_pkg::pal_index_t pal_idx;

    video_timing timing_i (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .hdump   (hdump),
        .vdump   (vdump),
        .sync    (sync)
    );

    video_regs regs_i (
        .clk    (clk),
        .rst    (rst),
        .cpu    (cpu),
        .cfg    (cfg),
        .pal_wr (pal_wr)
    );

    layer_mixer mixer_i (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .cfg     (cfg),
        .layers  (layers),
        .pal_idx (pal_idx)
    );

    // Blanking delay is kept inside the palette stage
    palette_lut palette_i (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .pal_wr   (pal_wr),
        .pal_idx  (pal_idx),
        .sync     (sync),
        .rgb      (rgb),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly)
    );

endmodule

`default_nettype wire

// File: source/palette_lut.sv
// Palette RAM lookup with colour expansion, output blanking and matching sync delay
`timescale 1ns/1ps
`default_nettype none
`include "video_defs.svh"

module palette_lut (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          pxl_cen,
    input  wire video_pkg::pal_wr_t      pal_wr,
    input  wire video_pkg::pal_index_t   pal_idx,
    input  wire video_pkg::sync_t        sync,
    output video_pkg::rgb_t              rgb,
    output logic                         lhbl_dly,
    output logic                         lvbl_dly
);

    logic [15:0] pal_ram [0:511];
    logic [15:0] ram_q;
    logic        blank_now;

    // Per stage {hb, vb}, stage 0 is the newest
    logic [`PAL_LATENCY-1:0][1:0] blank_sr;

    // CPU side port, not tied to the pixel enable
    always_ff @(posedge clk) begin
        if (pal_wr.we) begin
            pal_ram[pal_wr.addr] <= pal_wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            ram_q <= pal_ram[pal_idx];
        end
    end

    // Stage that lines up with ram_q
    assign blank_now = |blank_sr[`PAL_LATENCY-2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            blank_sr <= {`PAL_LATENCY{2'b11}};
            rgb      <= '0;
        end else if (pxl_cen) begin
            blank_sr <= {blank_sr[`PAL_LATENCY-2:0], sync.hb, sync.vb};
            if (blank_now) begin
                rgb <= '0;
            end else begin
                // Nibble repeated to fill the byte
                rgb.red   <= {ram_q[11:8], ram_q[11:8]};
                rgb.green <= {ram_q[7:4], ram_q[7:4]};
                rgb.blue  <= {ram_q[3:0], ram_q[3:0]};
            end
        end
    end

    assign lhbl_dly = !blank_sr[`PAL_LATENCY-1][1];
    assign lvbl_dly = !blank_sr[`PAL_LATENCY-1][0];

endmodule

`default_nettype wire

// File: source/layer_mixer.sv
// Layer priority mixer selecting the topmost enabled opaque pixel as palette index
`timescale 1ns/1ps
`default_nettype none
`include "video_defs.svh"

module layer_mixer (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       pxl_cen,
    input  wire video_pkg::mix_cfg_t  cfg,
    input  wire video_pkg::layers_t   layers,
    output video_pkg::pal_index_t     pal_idx
);

    video_pkg::pal_index_t mix_idx;
    logic [3:0]            order_mask;

    // Layer ids: 0 scr1, 1 scr2, 2 scr3, 3 obj
    function automatic video_pkg::layer_pxl_t layer_by_id(
        input video_pkg::layers_t l,
        input logic [1:0]         id
    );
        case (id)
            2'd0:    return l.scr1;
            2'd1:    return l.scr2;
            2'd2:    return l.scr3;
            default: return l.obj;
        endcase
    endfunction

    // First qualifying slot wins, backdrop is index 0
    always_comb begin
        logic                   found;
        logic [1:0]             id;
        video_pkg::layer_pxl_t  px;
        found   = 1'b0;
        mix_idx = '0;
        for (int slot = 0; slot < 4; slot++) begin
            id = cfg.layer_order[slot];
            px = layer_by_id(layers, id);
            if (!found && cfg.layer_en[id] && px.colour != 4'(`TRANSPARENT_COLOUR)) begin
                mix_idx = '{layer: id, pal: px.pal, colour: px.colour};
                found   = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pal_idx <= '0;
        end else if (pxl_cen) begin
            pal_idx <= mix_idx;
        end
    end

    // Which layers the order register names
    always_comb begin
        order_mask = '0;
        for (int slot = 0; slot < 4; slot++) begin
            order_mask[cfg.layer_order[slot]] = 1'b1;
        end
    end

    order_is_permutation: assert property (
        @(posedge clk) disable iff (rst)
        pxl_cen |-> order_mask == 4'hf
    ) else $error("layer_order repeats a layer: %h", cfg.layer_order);

endmodule

`default_nettype wire

// File: source/video_regs.sv
// CPU write decoder for the mixer registers and palette write forwarding
`timescale 1ns/1ps
`default_nettype none
`include "video_defs.svh"

module video_regs (
    input  wire                  clk,
    input  wire                  rst,
    input  wire video_pkg::cpu_wr_t cpu,
    output video_pkg::mix_cfg_t  cfg,
    output video_pkg::pal_wr_t   pal_wr
);

    logic                  pal_we_q;
    video_pkg::pal_index_t pal_addr_q;
    logic [15:0]           pal_data_q;
    logic                  reg_sel;

    assign reg_sel = cpu.we && !cpu.addr[9];

    // Mixer configuration, obj on top by default
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg.layer_order <= {2'd0, 2'd1, 2'd2, 2'd3};
            cfg.layer_en    <= 4'hf;
            pal_we_q        <= 1'b0;
        end else begin
            pal_we_q <= cpu.we && cpu.addr[9];
            if (reg_sel && cpu.addr[8:0] == 9'(`REG_LAYER_ORDER)) begin
                cfg.layer_order <= cpu.data[7:0];
            end
            if (reg_sel && cpu.addr[8:0] == 9'(`REG_LAYER_EN)) begin
                cfg.layer_en <= cpu.data[3:0];
            end
        end
    end

    // Palette address and data, qualified by pal_we_q
    always_ff @(posedge clk) begin
        if (cpu.we && cpu.addr[9]) begin
            pal_addr_q <= video_pkg::pal_index_t'(cpu.addr[8:0]);
            pal_data_q <= cpu.data;
        end
    end

    assign pal_wr = '{we: pal_we_q, addr: pal_addr_q, data: pal_data_q};

    // Address must be fully driven on every strobe
    cpu_addr_known: assert property (
        @(posedge clk) disable iff (rst)
        cpu.we |-> !$isunknown(cpu.addr)
    ) else $error("CPU write with unknown address");

endmodule

`default_nettype wire

// File: source/video_timing.sv
// Raster counters producing registered sync and blanking for the pixel pipeline
`timescale 1ns/1ps
`default_nettype none
`include "video_defs.svh"

module video_timing (
    input  wire                clk,
    input  wire                rst,
    input  wire                pxl_cen,
    output logic [8:0]         hdump,
    output logic [8:0]         vdump,
    output video_pkg::sync_t   sync
);

    logic [8:0] h_next;
    logic [8:0] v_next;
    logic       h_wrap;

    // Next position, line advances on the horizontal wrap
    always_comb begin
        h_wrap = (hdump == 9'(`H_TOTAL - 1));
        h_next = h_wrap ? 9'd0 : hdump + 9'd1;
        v_next = vdump;
        if (h_wrap) begin
            v_next = (vdump == 9'(`V_TOTAL - 1)) ? 9'd0 : vdump + 9'd1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdump <= '0;
            vdump <= '0;
            sync  <= '{hs: 1'b0, vs: 1'b0, hb: 1'b1, vb: 1'b1};
        end else if (pxl_cen) begin
            hdump <= h_next;
            vdump <= v_next;
            // Flags follow the new counter values
            sync.hb <= !(h_next >= 9'(`H_ACTIVE_START) && h_next < 9'(`H_ACTIVE_END));
            sync.vb <= !(v_next >= 9'(`V_ACTIVE_START) && v_next < 9'(`V_ACTIVE_END));
            sync.hs <= (h_next >= 9'(`H_SYNC_START)) && (h_next < 9'(`H_SYNC_END));
            sync.vs <= (v_next >= 9'(`V_SYNC_START)) && (v_next < 9'(`V_SYNC_END));
        end
    end

    // Sync window must sit inside horizontal blanking
    hs_in_hblank: assert property (
        @(posedge clk) disable iff (rst)
        sync.hs |-> sync.hb
    ) else $error("hs high outside horizontal blanking at hdump %0d", hdump);

endmodule

`default_nettype wire

// File: source/video_pkg.sv
// Packed struct types shared by the video pixel back end modules
`default_nettype none

package video_pkg;

    // One rendered layer pixel
    typedef struct packed {
        logic [2:0] pal;
        logic [3:0] colour;
    } layer_pxl_t;

    typedef struct packed {
        layer_pxl_t scr1;
        layer_pxl_t scr2;
        layer_pxl_t scr3;
        layer_pxl_t obj;
    } layers_t;

    // Palette RAM address
    typedef struct packed {
        logic [1:0] layer;
        logic [2:0] pal;
        logic [3:0] colour;
    } pal_index_t;

    // Addr bit 9 selects the palette
    typedef struct packed {
        logic        we;
        logic [9:0]  addr;
        logic [15:0] data;
    } cpu_wr_t;

    // Slot 0 of layer_order is drawn on top
    typedef struct packed {
        logic [3:0][1:0] layer_order;
        logic [3:0]      layer_en;
    } mix_cfg_t;

    typedef struct packed {
        logic        we;
        pal_index_t  addr;
        logic [15:0] data;
    } pal_wr_t;

    typedef struct packed {
        logic hs;
        logic vs;
        logic hb;
        logic vb;
    } sync_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

endpackage

`default_nettype wire

// File: source/video_defs.svh
// Raster sizes, register addresses and pipeline depth, included by RTL and testbench
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

// Horizontal raster, in pixel clock enables
`define H_TOTAL          512
`define H_ACTIVE_START   64
`define H_ACTIVE_END     448
`define H_SYNC_START     464
`define H_SYNC_END       496

// Vertical raster, in lines
`define V_TOTAL          262
`define V_ACTIVE_START   16
`define V_ACTIVE_END     240
`define V_SYNC_START     248
`define V_SYNC_END       251

// Enables from pixel sampling to colour output
`define PAL_LATENCY      3

// Colour code of an empty layer pixel
`define TRANSPARENT_COLOUR 15

// Mixer register addresses, addr bit 9 clear
`define REG_LAYER_ORDER  0
`define REG_LAYER_EN     1

`endif
